//--- filelist.f
src/fb_pkg.sv
src/fb_stripe_bank.sv
src/fb_stripe_reader.sv
src/fb_pixel_stream.sv
src/fb_write_port.sv
src/fb_display_top.sv
verif/tb_fb_display.sv

//--- run_sim.sh
#!/bin/sh
# build and run the frame buffer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f --top-module tb_fb_display

./obj_dir/Vtb_fb_display > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failed" sim.log; then
  exit 1
fi
exit 0

//--- verif/tb_fb_display.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fb_display;

  localparam int NUM_REWRITES = 24;
  localparam int WRITE_CYCLES = 8;
  localparam int FRAME_RECORDS = fb_pkg::H_WHOLE_LINE * fb_pkg::V_WHOLE_FRAME;
  // three frames plus both write phases with a factor of four margin
  localparam int WATCHDOG_CYCLES =
    4 * (3 * FRAME_RECORDS + (fb_pkg::FB_PIXELS + NUM_REWRITES) * WRITE_CYCLES);

  logic                          clk = 1'b0;
  logic                          reset;
  logic                          aw_valid;
  fb_pkg::axil_aw_t              aw;
  logic                          aw_ready;
  logic                          w_valid;
  fb_pkg::axil_w_t               w;
  logic                          w_ready;
  logic                          b_valid;
  fb_pkg::axil_b_t               b;
  logic                          b_ready;
  logic                          enable;
  logic                          pixel_valid;
  fb_pkg::pixel_out_t            pixel;

  logic [fb_pkg::DATA_W-1:0]     mem_model [fb_pkg::FB_PIXELS];
  logic [1:0]                    exp_resp;
  logic [31:0]                   lfsr_state;
  int                            exp_x;
  int                            exp_y;
  int                            cyc = 0;
  logic                          reset_d = 1'b1;
  logic                          exp_visible;
  logic                          exp_hsync;
  logic                          exp_vsync;
  logic                          frame_end_pos;
  logic [fb_pkg::ADDR_W-1:0]     exp_addr;
  logic [fb_pkg::PIXEL_BITS-1:0] exp_color;

  always #4 clk = ~clk;

  fb_display_top DUT (
    .clk         (clk),
    .reset       (reset),
    .aw_valid    (aw_valid),
    .aw          (aw),
    .aw_ready    (aw_ready),
    .w_valid     (w_valid),
    .w           (w),
    .w_ready     (w_ready),
    .b_valid     (b_valid),
    .b           (b),
    .b_ready     (b_ready),
    .enable      (enable),
    .pixel_valid (pixel_valid),
    .pixel       (pixel)
  );

  always @(posedge clk) begin
    cyc <= cyc + 1;
    reset_d <= reset;
  end

  // expected raster position advances once per output record
  always @(posedge clk) begin
    if (reset) begin
      exp_x <= 0;
      exp_y <= 0;
    end else if (pixel_valid) begin
      if (frame_end_pos) begin
        exp_x <= 0;
        exp_y <= 0;
      end else if (exp_x == fb_pkg::H_WHOLE_LINE - 1) begin
        exp_x <= 0;
        exp_y <= exp_y + 1;
      end else begin
        exp_x <= exp_x + 1;
      end
    end
  end

  // window rules for the expected position
  always_comb begin
    exp_visible = (exp_x < fb_pkg::H_VISIBLE) && (exp_y < fb_pkg::V_VISIBLE);
    exp_hsync = !((exp_x >= fb_pkg::H_VISIBLE + fb_pkg::H_FRONT_PORCH) &&
                  (exp_x < fb_pkg::H_VISIBLE + fb_pkg::H_FRONT_PORCH + fb_pkg::H_SYNC_PULSE));
    exp_vsync = !((exp_y >= fb_pkg::V_VISIBLE + fb_pkg::V_FRONT_PORCH) &&
                  (exp_y < fb_pkg::V_VISIBLE + fb_pkg::V_FRONT_PORCH + fb_pkg::V_SYNC_PULSE));
    frame_end_pos = (exp_x == fb_pkg::H_WHOLE_LINE - 1) &&
                    (exp_y == fb_pkg::V_WHOLE_FRAME - 1);
    exp_addr = fb_pkg::ADDR_W'(exp_y * fb_pkg::H_VISIBLE + exp_x);
    exp_color = '0;
    if (exp_visible) begin
      exp_color = mem_model[exp_y * fb_pkg::H_VISIBLE + exp_x][fb_pkg::PIXEL_BITS-1:0];
    end
  end

  a_quiet_in_reset : assert property (@(posedge clk)
    (cyc > 0) && (reset || reset_d) |-> !pixel_valid && !b_valid)
    else value_error("pixel valid or bvalid high during or right after reset");

  a_visible_flag : assert property (@(posedge clk) disable iff (reset)
    pixel_valid |-> pixel.visible == exp_visible)
    else value_error("visible flag does not match the raster position");

  a_sync_window : assert property (@(posedge clk) disable iff (reset)
    pixel_valid |-> (pixel.hsync == exp_hsync) && (pixel.vsync == exp_vsync))
    else value_error("hsync or vsync outside its window");

  a_visible_data : assert property (@(posedge clk) disable iff (reset)
    pixel_valid && exp_visible |-> (pixel.addr == exp_addr) && (pixel.color == exp_color))
    else value_error("visible pixel address or colour differs from the model");

  a_blank_black : assert property (@(posedge clk) disable iff (reset)
    pixel_valid && !exp_visible |-> pixel.color == '0)
    else value_error("blanking record with nonzero colour");

  a_hold_when_disabled : assert property (@(posedge clk) disable iff (reset)
    !enable |=> !pixel_valid)
    else value_error("pixel valid after a cycle with enable low");

  a_resp_code : assert property (@(posedge clk) disable iff (reset)
    b_valid |-> b.resp == exp_resp)
    else value_error("write response code is wrong");

  a_resp_held : assert property (@(posedge clk) disable iff (reset)
    b_valid && !b_ready |=> b_valid && $stable(b))
    else value_error("write response dropped or changed before bready");

  a_no_accept_in_resp : assert property (@(posedge clk) disable iff (reset)
    b_valid |-> !aw_ready && !w_ready)
    else value_error("write port accepted a write with a response pending");

  task automatic stop_with_failure();
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic value_error(input string msg);
    $display("Error at %0d ns: %s", $time, msg);
    stop_with_failure();
  endtask

  // 32-bit Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_bits(input int n, output logic [15:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      bits = {bits[14:0], lfsr_state[0]};
    end
  endtask

  // one AXI4-Lite write with random bready stalls
  task automatic write_pixel(input logic [fb_pkg::ADDR_W-1:0] addr,
                             input logic [fb_pkg::DATA_W-1:0] data,
                             input logic [fb_pkg::STRB_W-1:0] strb);
    logic        accepted;
    logic        responded;
    logic [15:0] bits;
    exp_resp = (int'(addr) < fb_pkg::FB_PIXELS) ? fb_pkg::RESP_OKAY : fb_pkg::RESP_SLVERR;
    aw_valid = 1'b1;
    aw.addr = addr;
    w_valid = 1'b1;
    w.data = data;
    w.strb = strb;
    // the write stays offered while its first response is pending
    // and goes through a second time once the port is free again
    for (int n = 0; n < 2; n++) begin
      accepted = 1'b0;
      responded = 1'b0;
      while (!accepted) begin
        @(negedge clk);
        accepted = aw_ready && w_ready;
        @(posedge clk);
        #1;
      end
      if (n == 1) begin
        aw_valid = 1'b0;
        w_valid = 1'b0;
      end
      while (!responded) begin
        draw_bits(1, bits);
        b_ready = bits[0];
        @(negedge clk);
        responded = b_valid && b_ready;
        @(posedge clk);
        #1;
      end
      b_ready = 1'b0;
    end
    // the model follows only OKAY writes
    if (exp_resp == fb_pkg::RESP_OKAY) begin
      for (int k = 0; k < fb_pkg::STRB_W; k++) begin
        if (strb[k]) begin
          mem_model[int'(addr)][8*k +: 8] = data[8*k +: 8];
        end
      end
    end
  endtask

  // runs the display up to the last record of a frame and then drops enable
  task automatic run_frame(input logic random_enable);
    logic        frame_end;
    logic [15:0] bits;
    frame_end = 1'b0;
    enable = 1'b1;
    while (!frame_end) begin
      @(posedge clk);
      #1;
      frame_end = pixel_valid && frame_end_pos;
      if (frame_end) begin
        enable = 1'b0;
      end else if (random_enable) begin
        draw_bits(1, bits);
        enable = bits[0];
      end
    end
  endtask

  initial begin
    logic [15:0]               bits;
    logic [15:0]               data;
    logic [fb_pkg::ADDR_W-1:0] addr;
    logic [fb_pkg::STRB_W-1:0] strb;
    reset = 1'b1;
    enable = 1'b0;
    aw_valid = 1'b0;
    aw = '0;
    w_valid = 1'b0;
    w = '0;
    b_ready = 1'b0;
    exp_resp = fb_pkg::RESP_OKAY;
    lfsr_state = 32'd98317;
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;

    // random picture with the display held off
    for (int p = 0; p < fb_pkg::FB_PIXELS; p++) begin
      draw_bits(16, data);
      write_pixel(fb_pkg::ADDR_W'(p), data, 2'b11);
    end

    run_frame(1'b0);
    repeat (6) @(posedge clk);
    #1;

    // partial rewrite where one access lands past the frame buffer
    for (int i = 0; i < NUM_REWRITES; i++) begin
      draw_bits(6, bits);
      addr = {2'b00, bits[5:0]};
      draw_bits(16, data);
      draw_bits(2, bits);
      strb = bits[1:0];
      // both strobes set so a stray write would alter a visible pixel
      if (i == NUM_REWRITES / 2) begin
        addr = fb_pkg::ADDR_W'(fb_pkg::FB_PIXELS) + addr;
        strb = '1;
      end
      write_pixel(addr, data, strb);
    end

    run_frame(1'b1);
    repeat (3) @(posedge clk);
    #1;
    $display("Test passed");
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: test sequence still running after %0d cycles", WATCHDOG_CYCLES);
    stop_with_failure();
  end

endmodule

`default_nettype wire

//--- src/fb_display_top.sv
`timescale 1ns/1ps
`default_nettype none

module fb_display_top (
  input  logic               clk,
  input  logic               reset,

  // CPU write port
  input  logic               aw_valid,
  input  fb_pkg::axil_aw_t   aw,
  output logic               aw_ready,
  input  logic               w_valid,
  input  fb_pkg::axil_w_t    w,
  output logic               w_ready,
  output logic               b_valid,
  output fb_pkg::axil_b_t    b,
  input  logic               b_ready,

  // display output
  input  logic               enable,
  output logic               pixel_valid,
  output fb_pkg::pixel_out_t pixel
);

  logic [fb_pkg::NUM_S-1:0]                wr_valid;
  logic [fb_pkg::NUM_S-1:0]                wr_ready;
  fb_pkg::bank_wr_t                        wr;
  logic [fb_pkg::NUM_S-1:0]                rd_valid;
  logic [fb_pkg::NUM_S-1:0]                rd_ready;
  fb_pkg::bank_rd_t [fb_pkg::NUM_S-1:0]    rd;
  logic [fb_pkg::NUM_S-1:0]                rvalid;
  logic [fb_pkg::NUM_S-1:0]                rready;
  fb_pkg::bank_rdata_t [fb_pkg::NUM_S-1:0] rdata;
  logic                                    req_valid;
  logic                                    req_ready;
  fb_pkg::line_req_t                       req;
  logic                                    beat_valid;
  logic                                    beat_ready;
  fb_pkg::line_beat_t                      beat;

  fb_write_port u_write_port (
    .clk      (clk),
    .reset    (reset),
    .aw_valid (aw_valid),
    .aw       (aw),
    .aw_ready (aw_ready),
    .w_valid  (w_valid),
    .w        (w),
    .w_ready  (w_ready),
    .b_valid  (b_valid),
    .b        (b),
    .b_ready  (b_ready),
    .wr_valid (wr_valid),
    .wr       (wr),
    .wr_ready (wr_ready)
  );

  // one bank per stripe
  for (genvar s = 0; s < fb_pkg::NUM_S; s++) begin : g_bank
    fb_stripe_bank u_bank (
      .clk      (clk),
      .reset    (reset),
      .wr_valid (wr_valid[s]),
      .wr       (wr),
      .wr_ready (wr_ready[s]),
      .rd_valid (rd_valid[s]),
      .rd       (rd[s]),
      .rd_ready (rd_ready[s]),
      .rvalid   (rvalid[s]),
      .rdata    (rdata[s]),
      .rready   (rready[s])
    );
  end

  fb_stripe_reader u_stripe_reader (
    .clk        (clk),
    .reset      (reset),
    .req_valid  (req_valid),
    .req        (req),
    .req_ready  (req_ready),
    .beat_valid (beat_valid),
    .beat       (beat),
    .beat_ready (beat_ready),
    .rd_valid   (rd_valid),
    .rd         (rd),
    .rd_ready   (rd_ready),
    .rvalid     (rvalid),
    .rdata      (rdata),
    .rready     (rready)
  );

  fb_pixel_stream u_pixel_stream (
    .clk        (clk),
    .reset      (reset),
    .enable     (enable),
    .valid      (pixel_valid),
    .pixel      (pixel),
    .req_valid  (req_valid),
    .req        (req),
    .req_ready  (req_ready),
    .beat_valid (beat_valid),
    .beat       (beat),
    .beat_ready (beat_ready)
  );

endmodule

`default_nettype wire

//--- src/fb_write_port.sv
`timescale 1ns/1ps
`default_nettype none

module fb_write_port (
  input  logic                     clk,
  input  logic                     reset,

  // AXI4-Lite write channels
  input  logic                     aw_valid,
  input  fb_pkg::axil_aw_t         aw,
  output logic                     aw_ready,
  input  logic                     w_valid,
  input  fb_pkg::axil_w_t          w,
  output logic                     w_ready,
  output logic                     b_valid,
  output fb_pkg::axil_b_t          b,
  input  logic                     b_ready,

  // stripe writes, payload shared by all banks
  output logic [fb_pkg::NUM_S-1:0] wr_valid,
  output fb_pkg::bank_wr_t         wr,
  input  logic [fb_pkg::NUM_S-1:0] wr_ready
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WRITE,
    ST_RESP
  } state_t;

  state_t                 state;
  logic [fb_pkg::S_W-1:0] wr_s;
  logic                   accept;
  logic                   out_of_range;

  // address and data are taken together
  assign accept = (state == ST_IDLE) && aw_valid && w_valid;
  assign aw_ready = accept;
  assign w_ready = accept;
  assign out_of_range = (aw.addr >= fb_pkg::ADDR_W'(fb_pkg::FB_PIXELS));

  assign b_valid = (state == ST_RESP);

  always_comb begin
    for (int s = 0; s < fb_pkg::NUM_S; s++) begin
      wr_valid[s] = (state == ST_WRITE) && (wr_s == fb_pkg::S_W'(s));
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: begin
          if (accept) begin
            state <= out_of_range ? ST_RESP : ST_WRITE;
          end
        end
        ST_WRITE: begin
          if (wr_ready[wr_s]) begin
            state <= ST_RESP;
          end
        end
        ST_RESP: begin
          if (b_ready) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      wr_s <= fb_pkg::S_W'(aw.addr % fb_pkg::NUM_S);
      wr.word <= fb_pkg::BANK_AW'(aw.addr / fb_pkg::NUM_S);
      wr.data <= w.data;
      wr.strb <= w.strb;
      b.resp <= out_of_range ? fb_pkg::RESP_SLVERR : fb_pkg::RESP_OKAY;
    end
  end

endmodule

`default_nettype wire

//--- src/fb_pixel_stream.sv
`timescale 1ns/1ps
`default_nettype none

module fb_pixel_stream (
  input  logic               clk,
  input  logic               reset,

  // display side
  input  logic               enable,
  output logic               valid,
  output fb_pkg::pixel_out_t pixel,

  // line fetch to the stripe reader
  output logic               req_valid,
  output fb_pkg::line_req_t  req,
  input  logic               req_ready,
  input  logic               beat_valid,
  input  fb_pkg::line_beat_t beat,
  output logic               beat_ready
);

  logic [fb_pkg::X_BITS-1:0] x;
  logic [fb_pkg::Y_BITS-1:0] y;
  logic [fb_pkg::Y_BITS-1:0] fetch_y;
  logic                      need_req;
  logic                      launch;
  logic                      in_visible;
  logic                      beat_fire;
  logic                      step;
  logic                      x_last;
  logic                      y_last;
  logic                      at_origin;
  logic                      hsync_on;
  logic                      vsync_on;

  assign in_visible = (x < fb_pkg::X_BITS'(fb_pkg::H_VISIBLE)) &&
                      (y < fb_pkg::Y_BITS'(fb_pkg::V_VISIBLE));

  assign beat_ready = enable && in_visible;
  assign beat_fire = beat_valid && beat_ready;

  // visible pixels wait for data, blanking runs on enable alone
  assign step = in_visible ? beat_fire : enable;

  assign x_last = (x == fb_pkg::X_BITS'(fb_pkg::H_WHOLE_LINE - 1));
  assign y_last = (y == fb_pkg::Y_BITS'(fb_pkg::V_WHOLE_FRAME - 1));
  assign at_origin = (x == '0) && (y == '0);

  assign hsync_on = (x >= fb_pkg::X_BITS'(fb_pkg::H_SYNC_START)) &&
                    (x < fb_pkg::X_BITS'(fb_pkg::H_SYNC_END));
  assign vsync_on = (y >= fb_pkg::Y_BITS'(fb_pkg::V_SYNC_START)) &&
                    (y < fb_pkg::Y_BITS'(fb_pkg::V_SYNC_END));

  // raster counters
  always_ff @(posedge clk) begin
    if (reset) begin
      x <= '0;
      y <= '0;
    end else if (step) begin
      if (x_last) begin
        x <= '0;
        y <= y_last ? '0 : y + 1'b1;
      end else begin
        x <= x + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid <= 1'b0;
    end else begin
      valid <= step;
    end
  end

  // one record per raster step
  always_ff @(posedge clk) begin
    if (step) begin
      pixel.visible <= in_visible;
      pixel.hsync <= in_visible || !hsync_on;
      pixel.vsync <= in_visible || !vsync_on;
      pixel.addr <= fb_pkg::ADDR_W'(y) * fb_pkg::ADDR_W'(fb_pkg::H_VISIBLE) +
                    fb_pkg::ADDR_W'(x);
      pixel.color <= in_visible ? beat.data[fb_pkg::PIXEL_BITS-1:0] : '0;
    end
  end

  // line 0 is only fetched once the raster is back at the origin with the display running,
  // later lines go out right after the previous line's last beat
  assign launch = need_req && !req_valid &&
                  ((fetch_y != '0) || (at_origin && enable));

  always_ff @(posedge clk) begin
    if (reset) begin
      req_valid <= 1'b0;
      need_req <= 1'b1;
      fetch_y <= '0;
    end else begin
      if (req_valid && req_ready) begin
        req_valid <= 1'b0;
        need_req <= 1'b0;
      end else if (launch) begin
        req_valid <= 1'b1;
      end
      if (beat_fire && beat.last) begin
        need_req <= 1'b1;
        if (fetch_y == fb_pkg::Y_BITS'(fb_pkg::V_VISIBLE - 1)) begin
          fetch_y <= '0;
        end else begin
          fetch_y <= fetch_y + 1'b1;
        end
      end
    end
  end

  assign req.addr = fb_pkg::ADDR_W'(fetch_y) * fb_pkg::ADDR_W'(fb_pkg::H_VISIBLE);
  assign req.len = fb_pkg::LEN_W'(fb_pkg::H_VISIBLE - 1);

  // the reader's line framing lines up with the raster
  a_beat_matches_raster : assert property (
    @(posedge clk) disable iff (reset)
    beat_fire |-> (y == fetch_y) &&
                  (beat.last == (x == fb_pkg::X_BITS'(fb_pkg::H_VISIBLE - 1)))
  );

endmodule

`default_nettype wire

//--- src/fb_stripe_reader.sv
`timescale 1ns/1ps
`default_nettype none

module fb_stripe_reader (
  input  logic                                      clk,
  input  logic                                      reset,

  // line requests from the pixel stream
  input  logic                                      req_valid,
  input  fb_pkg::line_req_t                         req,
  output logic                                      req_ready,

  // in-order line data back to the pixel stream
  output logic                                      beat_valid,
  output fb_pkg::line_beat_t                        beat,
  input  logic                                      beat_ready,

  // one read port per stripe bank
  output logic [fb_pkg::NUM_S-1:0]                  rd_valid,
  output fb_pkg::bank_rd_t [fb_pkg::NUM_S-1:0]      rd,
  input  logic [fb_pkg::NUM_S-1:0]                  rd_ready,
  input  logic [fb_pkg::NUM_S-1:0]                  rvalid,
  input  fb_pkg::bank_rdata_t [fb_pkg::NUM_S-1:0]   rdata,
  output logic [fb_pkg::NUM_S-1:0]                  rready
);

  logic                      busy;
  logic [fb_pkg::ADDR_W-1:0] base;
  logic [fb_pkg::LEN_W-1:0]  len;
  logic [fb_pkg::LEN_W:0]    issue_cnt;
  logic [fb_pkg::LEN_W:0]    ret_cnt;
  logic [fb_pkg::NUM_S-1:0]  pending;
  logic [fb_pkg::ADDR_W-1:0] issue_addr;
  logic [fb_pkg::ADDR_W-1:0] ret_addr;
  logic [fb_pkg::S_W-1:0]    issue_s;
  logic [fb_pkg::S_W-1:0]    ret_s;
  logic                      issue_open;
  logic                      issue_fire;
  logic                      beat_fire;
  logic                      req_fire;

  assign req_ready = !busy;
  assign req_fire = req_valid && req_ready;

  // pixel p sits in stripe p mod NUM_S at word p / NUM_S
  assign issue_addr = base + fb_pkg::ADDR_W'(issue_cnt);
  assign ret_addr = base + fb_pkg::ADDR_W'(ret_cnt);
  assign issue_s = fb_pkg::S_W'(issue_addr % fb_pkg::NUM_S);
  assign ret_s = fb_pkg::S_W'(ret_addr % fb_pkg::NUM_S);

  assign issue_open = busy && (issue_cnt <= {1'b0, len});

  always_comb begin
    for (int s = 0; s < fb_pkg::NUM_S; s++) begin
      // at most one read in flight per stripe
      rd_valid[s] = issue_open && (issue_s == fb_pkg::S_W'(s)) && !pending[s];
      rd[s].word = fb_pkg::BANK_AW'(issue_addr / fb_pkg::NUM_S);
      // only the stripe holding the next pixel in order is drained
      rready[s] = busy && beat_ready && (ret_s == fb_pkg::S_W'(s));
    end
  end

  assign issue_fire = |(rd_valid & rd_ready);

  assign beat_valid = busy && rvalid[ret_s];
  assign beat.data = rdata[ret_s].data;
  assign beat.last = (ret_cnt == {1'b0, len});
  assign beat_fire = beat_valid && beat_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      busy <= 1'b0;
      issue_cnt <= '0;
      ret_cnt <= '0;
      pending <= '0;
    end else begin
      if (req_fire) begin
        busy <= 1'b1;
        issue_cnt <= '0;
        ret_cnt <= '0;
      end else begin
        if (issue_fire) begin
          issue_cnt <= issue_cnt + 1'b1;
        end
        if (beat_fire) begin
          ret_cnt <= ret_cnt + 1'b1;
          if (beat.last) begin
            busy <= 1'b0;
          end
        end
      end
      pending <= (pending | (rd_valid & rd_ready)) & ~(rvalid & rready);
    end
  end

  always_ff @(posedge clk) begin
    if (req_fire) begin
      base <= req.addr;
      len <= req.len;
    end
  end

  a_ret_behind_issue : assert property (
    @(posedge clk) disable iff (reset)
    ret_cnt <= issue_cnt
  );

  // every beat comes from a read this reader issued and the bank answered cleanly
  a_beat_from_issued_read : assert property (
    @(posedge clk) disable iff (reset)
    beat_fire |-> pending[ret_s] && (rdata[ret_s].resp == fb_pkg::RESP_OKAY)
  );

endmodule

`default_nettype wire

//--- src/fb_stripe_bank.sv
`timescale 1ns/1ps
`default_nettype none

module fb_stripe_bank (
  input  logic                clk,
  input  logic                reset,

  // writer side
  input  logic                wr_valid,
  input  fb_pkg::bank_wr_t    wr,
  output logic                wr_ready,

  // reader side
  input  logic                rd_valid,
  input  fb_pkg::bank_rd_t    rd,
  output logic                rd_ready,
  output logic                rvalid,
  output fb_pkg::bank_rdata_t rdata,
  input  logic                rready
);

  logic [fb_pkg::DATA_W-1:0] mem [fb_pkg::BANK_DEPTH];
  logic [fb_pkg::DATA_W-1:0] rdata_q;
  logic                      rd_fire;
  logic                      mem_we;

  // a read is granted whenever the output slot is free or being drained
  assign rd_ready = !rvalid || rready;
  // writes only get the port when no read is asking for it
  assign wr_ready = !rd_valid;

  assign rd_fire = rd_valid && rd_ready;
  assign mem_we = wr_valid && wr_ready;

  always_ff @(posedge clk) begin
    if (mem_we) begin
      for (int b = 0; b < fb_pkg::STRB_W; b++) begin
        if (wr.strb[b]) begin
          mem[wr.word][8*b +: 8] <= wr.data[8*b +: 8];
        end
      end
    end
  end

  // read data lands one cycle after the grant
  always_ff @(posedge clk) begin
    if (rd_fire) begin
      rdata_q <= mem[rd.word];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rvalid <= 1'b0;
    end else if (rd_fire) begin
      rvalid <= 1'b1;
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

  assign rdata.data = rdata_q;
  assign rdata.resp = fb_pkg::RESP_OKAY;

  // a write held off by a read keeps its request steady until the bank takes it
  a_write_held : assert property (
    @(posedge clk) disable iff (reset)
    wr_valid && !wr_ready |=> wr_valid && $stable(wr)
  );

  // returned data waits for the reader
  a_rdata_held : assert property (
    @(posedge clk) disable iff (reset)
    rvalid && !rready |=> rvalid && $stable(rdata)
  );

endmodule

`default_nettype wire

//--- src/fb_pkg.sv
`default_nettype none

package fb_pkg;

  // stripe and bus geometry
  localparam int NUM_S = 2;
  localparam int S_W = (NUM_S > 1) ? $clog2(NUM_S) : 1;
  localparam int PIXEL_BITS = 12;
  localparam int DATA_W = 16;
  localparam int STRB_W = DATA_W / 8;
  localparam int ADDR_W = 8;

  // tiny simulation video mode
  localparam int H_VISIBLE = 16;
  localparam int H_FRONT_PORCH = 2;
  localparam int H_SYNC_PULSE = 3;
  localparam int H_BACK_PORCH = 3;
  localparam int H_WHOLE_LINE = H_VISIBLE + H_FRONT_PORCH + H_SYNC_PULSE + H_BACK_PORCH;

  localparam int V_VISIBLE = 4;
  localparam int V_FRONT_PORCH = 1;
  localparam int V_SYNC_PULSE = 1;
  localparam int V_BACK_PORCH = 1;
  localparam int V_WHOLE_FRAME = V_VISIBLE + V_FRONT_PORCH + V_SYNC_PULSE + V_BACK_PORCH;

  // sync windows, end is exclusive
  localparam int H_SYNC_START = H_VISIBLE + H_FRONT_PORCH;
  localparam int H_SYNC_END = H_SYNC_START + H_SYNC_PULSE;
  localparam int V_SYNC_START = V_VISIBLE + V_FRONT_PORCH;
  localparam int V_SYNC_END = V_SYNC_START + V_SYNC_PULSE;

  localparam int FB_PIXELS = H_VISIBLE * V_VISIBLE;
  localparam int BANK_DEPTH = FB_PIXELS / NUM_S;
  localparam int BANK_AW = $clog2(BANK_DEPTH);
  localparam int X_BITS = $clog2(H_WHOLE_LINE);
  localparam int Y_BITS = $clog2(V_WHOLE_FRAME);
  localparam int LEN_W = $clog2(H_VISIBLE);

  localparam logic [1:0] RESP_OKAY = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
  } axil_aw_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
  } axil_w_t;

  typedef struct packed {
    logic [1:0] resp;
  } axil_b_t;

  typedef struct packed {
    logic [BANK_AW-1:0] word;
    logic [DATA_W-1:0]  data;
    logic [STRB_W-1:0]  strb;
  } bank_wr_t;

  typedef struct packed {
    logic [BANK_AW-1:0] word;
  } bank_rd_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [1:0]        resp;
  } bank_rdata_t;

  // len is the pixel count minus one
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [LEN_W-1:0]  len;
  } line_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic              last;
  } line_beat_t;

  // syncs are active low
  typedef struct packed {
    logic                  visible;
    logic                  hsync;
    logic                  vsync;
    logic [ADDR_W-1:0]     addr;
    logic [PIXEL_BITS-1:0] color;
  } pixel_out_t;

endpackage

`default_nettype wire
